/* rtl/dut_wrapper_soc.sv */
`timescale 1ns/1ns

module dut_wrapper_soc (
    input  logic                                   sysclk,
    input  logic                                   reset,
    input  logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg0,  // System control
    input  logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg1,  // Debug RF address
    input  logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg2,  // ROM control
    input  logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg3,  // ROM write word
    input  logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg4,  // Reserved
    output logic [soc_host_pkg::host_data_width-1:0] write_to_slv_reg5,   // PC
    output logic [soc_host_pkg::host_data_width-1:0] write_to_slv_reg6,   // ROM read word
    output logic [soc_host_pkg::host_data_width-1:0] write_to_slv_reg7    // Debug register
);

    ////////////////////////////////////////////////////////////
    // Host fields
    ////////////////////////////////////////////////////////////
    logic rst_host, clk_host, clk_select;
    logic host_we, host_select;
    logic [mips_pkg::rom_addr_width-1:0]    host_addr;
    logic [soc_host_pkg::rf_addr_width-1:0] dbg_addr;

    assign rst_host    = read_from_slv_reg0[soc_host_pkg::ctrl_rst_bit];
    assign clk_host    = read_from_slv_reg0[soc_host_pkg::ctrl_clk_bit];
    assign clk_select  = read_from_slv_reg0[soc_host_pkg::ctrl_sel_bit];
    assign dbg_addr    = read_from_slv_reg1[soc_host_pkg::rf_addr_width-1:0];
    assign host_we     = read_from_slv_reg2[soc_host_pkg::rom_we_bit];
    assign host_addr   = read_from_slv_reg2[soc_host_pkg::rom_addr_lsb +: mips_pkg::rom_addr_width];
    assign host_select = read_from_slv_reg2[soc_host_pkg::rom_sel_bit];

    // Block interconnect
    logic core_reset, run_enable, instr_done;
    logic core_req, core_busy, rom_gnt_core;
    logic rom_en, rom_we;
    logic [mips_pkg::rom_addr_width-1:0] core_addr, rom_addr;
    logic [mips_pkg::data_width-1:0]     rom_wdata, rom_rdata, pc_current;
    logic [mips_pkg::reg_addr_width-1:0] rs_addr, rt_addr, wr_addr;
    logic [mips_pkg::data_width-1:0]     rs_data, rt_data, wr_data, dbg_data;
    logic                                wr_en;

    run_control i_run_control (
        .sysclk(sysclk), .reset(reset), .rst_host(rst_host), .clk_host(clk_host),
        .clk_select(clk_select), .instr_done(instr_done),
        .core_reset(core_reset), .run_enable(run_enable)
    );

    rom_arbiter i_rom_arbiter (
        .sysclk(sysclk), .reset(reset), .host_select(host_select), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(read_from_slv_reg3),
        .core_req(core_req), .core_addr(core_addr), .core_busy(core_busy),
        .rom_en(rom_en), .rom_we(rom_we), .rom_addr(rom_addr), .rom_wdata(rom_wdata),
        .rom_gnt_core(rom_gnt_core)
    );

    program_rom i_program_rom (
        .sysclk(sysclk), .rom_en(rom_en), .rom_we(rom_we), .rom_addr(rom_addr),
        .rom_wdata(rom_wdata), .rom_rdata(rom_rdata)
    );

    reg_file i_reg_file (
        .sysclk(sysclk), .reset(reset), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .dbg_addr(dbg_addr),
        .rs_data(rs_data), .rt_data(rt_data), .dbg_data(dbg_data)
    );

    mips_core i_mips_core (
        .sysclk(sysclk), .core_reset(core_reset), .run_enable(run_enable),
        .rom_gnt_core(rom_gnt_core), .rom_rdata(rom_rdata),
        .rom_req(core_req), .rom_addr(core_addr), .core_busy(core_busy),
        .instr_done(instr_done), .pc_current(pc_current),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    // Results back to the host
    assign write_to_slv_reg5 = pc_current;
    assign write_to_slv_reg6 = rom_rdata;  // Shared read bus
    assign write_to_slv_reg7 = dbg_data;

endmodule

/* rtl/mips_core.sv */
`timescale 1ns/1ns

module mips_core (
    input  logic                                sysclk,
    input  logic                                core_reset,
    input  logic                                run_enable,
    input  logic                                rom_gnt_core,
    input  logic [mips_pkg::data_width-1:0]     rom_rdata,
    output logic                                rom_req,
    output logic [mips_pkg::rom_addr_width-1:0] rom_addr,
    output logic                                core_busy,
    output logic                                instr_done,
    output logic [mips_pkg::data_width-1:0]     pc_current,
    output logic [mips_pkg::reg_addr_width-1:0] rs_addr,
    output logic [mips_pkg::reg_addr_width-1:0] rt_addr,
    input  logic [mips_pkg::data_width-1:0]     rs_data,
    input  logic [mips_pkg::data_width-1:0]     rt_data,
    output logic                                wr_en,
    output logic [mips_pkg::reg_addr_width-1:0] wr_addr,
    output logic [mips_pkg::data_width-1:0]     wr_data
);

    mips_pkg::core_state_e           state;
    logic [mips_pkg::data_width-1:0] instr_q;      // Fetched word
    mips_pkg::opcode_e               opcode;
    mips_pkg::funct_e                funct;
    logic [mips_pkg::data_width-1:0] imm_sext;
    logic [mips_pkg::data_width-1:0] pc_plus4;
    logic [mips_pkg::data_width-1:0] pc_next;
    logic [mips_pkg::data_width-1:0] alu_result;
    logic                            writes_rf;    // Instruction has a destination

    ////////////////////////////////////////////////////////////
    // Sequencing: fetch, wait_rom, execute
    ////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (core_reset) begin
            state      <= mips_pkg::st_fetch;
            pc_current <= '0;
        end else begin
            case (state)
                mips_pkg::st_fetch: begin
                    if (rom_gnt_core) state <= mips_pkg::st_wait_rom;  // Stall until granted
                end
                mips_pkg::st_wait_rom: state <= mips_pkg::st_execute;
                mips_pkg::st_execute: begin
                    if (run_enable) begin
                        state      <= mips_pkg::st_fetch;
                        pc_current <= pc_next;  // PC moves only here
                    end
                end
                default: state <= mips_pkg::st_fetch;
            endcase
        end
    end

    // ROM word arrives during wait_rom
    always_ff @(posedge sysclk) begin
        if (state == mips_pkg::st_wait_rom) instr_q <= rom_rdata;
    end

    assign rom_req    = (state == mips_pkg::st_fetch) && run_enable;
    assign rom_addr   = pc_current[mips_pkg::rom_addr_width+1:2];  // Word address
    assign core_busy  = (state == mips_pkg::st_wait_rom) || rom_gnt_core;  // Keep grant
    assign instr_done = (state == mips_pkg::st_execute) && run_enable;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////
    assign opcode   = mips_pkg::opcode_e'(instr_q[31:26]);
    assign funct    = mips_pkg::funct_e'(instr_q[5:0]);
    assign rs_addr  = instr_q[25:21];
    assign rt_addr  = instr_q[20:16];
    assign imm_sext = {{16{instr_q[15]}}, instr_q[15:0]};
    assign pc_plus4 = pc_current + 32'd4;

    // ALU and next PC
    always_comb begin
        alu_result = '0;
        writes_rf  = 1'b0;
        wr_addr    = instr_q[15:11];  // rd for R-type
        pc_next    = pc_plus4;
        case (opcode)
            mips_pkg::op_r_type: begin
                writes_rf = 1'b1;
                case (funct)
                    mips_pkg::fn_add: alu_result = rs_data + rt_data;
                    mips_pkg::fn_sub: alu_result = rs_data - rt_data;
                    mips_pkg::fn_and: alu_result = rs_data & rt_data;
                    mips_pkg::fn_or:  alu_result = rs_data | rt_data;
                    mips_pkg::fn_slt: begin
                        alu_result = {{(mips_pkg::data_width-1){1'b0}},
                                      $signed(rs_data) < $signed(rt_data)};  // Signed compare
                    end
                    default: writes_rf = 1'b0;  // Unknown funct is a nop
                endcase
            end
            mips_pkg::op_addi: begin
                writes_rf  = 1'b1;
                wr_addr    = instr_q[20:16];  // rt is the destination
                alu_result = rs_data + imm_sext;
            end
            mips_pkg::op_beq: begin
                if (rs_data == rt_data) pc_next = pc_plus4 + {imm_sext[29:0], 2'b00};
            end
            mips_pkg::op_j: begin
                pc_next = {4'b0000, instr_q[25:0], 2'b00};  // Target times 4
            end
            default: ;  // Nop
        endcase
    end

    // Write back on the edge that ends execute
    assign wr_en   = instr_done && writes_rf;
    assign wr_data = alu_result;

endmodule

/* rtl/mips_pkg.sv */
package mips_pkg;

    // Core sizes
    localparam int data_width     = 32;  // Word size
    localparam int rom_depth      = 64;  // Program words
    localparam int rom_addr_width = 6;   // Word address into the ROM
    localparam int reg_count      = 32;  // Register file entries
    localparam int reg_addr_width = 5;

    // Primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        op_r_type = 6'h00,
        op_j      = 6'h02,
        op_beq    = 6'h04,
        op_addi   = 6'h08
    } opcode_e;

    // R-type function codes, instr[5:0]
    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    // One instruction in flight, three states
    typedef enum logic [1:0] {
        st_fetch    = 2'd0,  // Request ROM word at PC
        st_wait_rom = 2'd1,  // ROM answers this cycle
        st_execute  = 2'd2   // ALU, write back, PC update
    } core_state_e;

endpackage

/* rtl/program_rom.sv */
`timescale 1ns/1ns

module program_rom (
    input  logic                                sysclk,
    input  logic                                rom_en,
    input  logic                                rom_we,
    input  logic [mips_pkg::rom_addr_width-1:0] rom_addr,
    input  logic [mips_pkg::data_width-1:0]     rom_wdata,
    output logic [mips_pkg::data_width-1:0]     rom_rdata
);

    // Program store, written by the host loader
    logic [mips_pkg::data_width-1:0] mem [mips_pkg::rom_depth];

    // Single port, registered read
    // Old word comes out on a write
    always_ff @(posedge sysclk) begin
        if (rom_en) begin
            rom_rdata <= mem[rom_addr];
            if (rom_we) begin
                mem[rom_addr] <= rom_wdata;
            end
        end
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                                sysclk,
    input  logic                                reset,
    input  logic [mips_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [mips_pkg::reg_addr_width-1:0] rt_addr,
    input  logic                                wr_en,
    input  logic [mips_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [mips_pkg::data_width-1:0]     wr_data,
    input  logic [mips_pkg::reg_addr_width-1:0] dbg_addr,  // Host probe
    output logic [mips_pkg::data_width-1:0]     rs_data,
    output logic [mips_pkg::data_width-1:0]     rt_data,
    output logic [mips_pkg::data_width-1:0]     dbg_data
);

    logic [mips_pkg::data_width-1:0] regs [mips_pkg::reg_count];

    always_ff @(posedge sysclk) begin
        if (reset) begin
            for (int i = 0; i < mips_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin  // r0 not writable
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads, r0 forced to zero
    assign rs_data  = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data  = (rt_addr == '0) ? '0 : regs[rt_addr];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

/* rtl/rom_arbiter.sv */
`timescale 1ns/1ns

module rom_arbiter (
    input  logic                                sysclk,
    input  logic                                reset,
    input  logic                                host_select,
    input  logic                                host_we,
    input  logic [mips_pkg::rom_addr_width-1:0] host_addr,
    input  logic [mips_pkg::data_width-1:0]     host_wdata,
    input  logic                                core_req,
    input  logic [mips_pkg::rom_addr_width-1:0] core_addr,
    input  logic                                core_busy,
    output logic                                rom_en,
    output logic                                rom_we,
    output logic [mips_pkg::rom_addr_width-1:0] rom_addr,
    output logic [mips_pkg::data_width-1:0]     rom_wdata,
    output logic                                rom_gnt_core
);

    logic gnt_host_q;  // 1 = host owns the port

    // Ownership follows host_select, but never while a core fetch is open
    always_ff @(posedge sysclk) begin
        if (reset) begin
            gnt_host_q <= 1'b1;  // Host first, for program load
        end else if (!core_busy) begin
            gnt_host_q <= host_select;
        end
    end

    // Fetch issued this cycle
    assign rom_gnt_core = !gnt_host_q && core_req;

    ////////////////////////////////////////////////////////////
    // Port steering
    ////////////////////////////////////////////////////////////
    assign rom_en    = gnt_host_q ? host_select : core_req;
    assign rom_we    = gnt_host_q && host_select && host_we;  // Core only reads
    assign rom_addr  = gnt_host_q ? host_addr : core_addr;
    assign rom_wdata = gnt_host_q ? host_wdata : '0;

endmodule

/* rtl/run_control.sv */
`timescale 1ns/1ns

module run_control (
    input  logic sysclk,
    input  logic reset,
    input  logic rst_host,
    input  logic clk_host,
    input  logic clk_select,  // 1 = free run, 0 = single step
    input  logic instr_done,
    output logic core_reset,
    output logic run_enable
);

    logic clk_host_q;    // Previous step level
    logic step_edge;
    logic step_pending;  // One instruction allowed

    assign step_edge = clk_host && !clk_host_q;

    always_ff @(posedge sysclk) begin
        core_reset <= reset || rst_host;  // External or host reset
        clk_host_q <= clk_host;
    end

    // Opened by a step edge, closed when the instruction retires
    always_ff @(posedge sysclk) begin
        if (reset || rst_host || clk_select) begin
            step_pending <= 1'b0;
        end else if (step_edge) begin
            step_pending <= 1'b1;
        end else if (instr_done) begin
            step_pending <= 1'b0;
        end
    end

    assign run_enable = clk_select || step_pending;  // Free run passes always

endmodule

/* rtl/soc_host_pkg.sv */
package soc_host_pkg;

    ////////////////////////////////////////////////////////////
    // Host register window
    ////////////////////////////////////////////////////////////

    // One host register word
    localparam int host_data_width = 32;

    // Register 0, system control
    localparam int ctrl_rst_bit = 0;   // Host reset, active high
    localparam int ctrl_clk_bit = 1;   // Step clock, rising edge runs one instruction
    localparam int ctrl_sel_bit = 2;   // Clock select, 1 = free run

    // Register 1, debug register-file address
    localparam int rf_addr_width = 5;  // Low bits only

    // Register 2, ROM control
    localparam int rom_we_bit   = 0;   // Host write enable
    localparam int rom_addr_lsb = 1;   // Word address in bits 6..1
    localparam int rom_sel_bit  = 7;   // Host owns the ROM port

    // Register 3 is the ROM write word, register 4 is reserved
    // Registers 5..7 return PC, ROM read word and debug register

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dut_wrapper_soc -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_dut_wrapper_soc
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

/* sources.f */
rtl/soc_host_pkg.sv
rtl/mips_pkg.sv
rtl/run_control.sv
rtl/rom_arbiter.sv
rtl/program_rom.sv
rtl/reg_file.sv
rtl/mips_core.sv
rtl/dut_wrapper_soc.sv
tb/dut_wrapper_soc_sva.sv
tb/tb_dut_wrapper_soc.sv

/* tb/dut_wrapper_soc_sva.sv */
`timescale 1ns/1ns

module dut_wrapper_soc_sva (
    input logic                            sysclk,
    input logic                            reset,
    input logic                            rom_we,
    input logic                            gnt_host,    // Arbiter owner, 1 = host
    input mips_pkg::core_state_e           core_state,
    input logic [mips_pkg::data_width-1:0] pc_current,
    input logic                            instr_done,
    input logic                            run_enable
);

    // Core fetch in flight, no host write
    rom_write_owner: assert property (@(posedge sysclk) disable iff (reset)
        core_state == mips_pkg::st_wait_rom |-> !rom_we)
        else $error("ROM written while the core owns the port");

    // Open fetch keeps its owner
    grant_hold: assert property (@(posedge sysclk) disable iff (reset)
        core_state == mips_pkg::st_wait_rom |=> $stable(gnt_host))
        else $error("Grant moved during wait_rom");

    pc_aligned: assert property (@(posedge sysclk) disable iff (reset)
        pc_current[1:0] == 2'b00)
        else $error("PC not word aligned");

    // Permission already held before the instruction ends
    done_needs_run: assert property (@(posedge sysclk) disable iff (reset)
        $rose(instr_done) |-> $past(run_enable))
        else $error("instr_done rose without run_enable");

endmodule

// Arbiter owner and core state taken from inside the wrapper
bind dut_wrapper_soc dut_wrapper_soc_sva i_dut_wrapper_soc_sva (
    .sysclk(sysclk), .reset(reset), .rom_we(rom_we),
    .gnt_host(i_rom_arbiter.gnt_host_q), .core_state(i_mips_core.state),
    .pc_current(pc_current), .instr_done(instr_done), .run_enable(run_enable)
);

/* tb/soc_stimulus.txt */
# One value per line. Counts and register numbers decimal, words and PCs hex.
# Sections: word count, words, step count, PC after each step, final PC, probes
16
20010006    # 00 addi $1, $0, 6
2002fffd    # 04 addi $2, $0, -3
00221820    # 08 add  $3, $1, $2
00222022    # 0c sub  $4, $1, $2
00222824    # 10 and  $5, $1, $2
00243025    # 14 or   $6, $1, $4
0041382a    # 18 slt  $7, $2, $1
0022402a    # 1c slt  $8, $1, $2
10220005    # 20 beq  $1, $2, +5 not taken
10630001    # 24 beq  $3, $3, +1 taken
20090077    # 28 addi $9, $0, 0x77 skipped
0800000d    # 2c j    0x34
20090055    # 30 addi $9, $0, 0x55 skipped
214a0001    # 34 addi $10, $10, 1
1147fffe    # 38 beq  $10, $7, -2
0800000f    # 3c j    0x3c
14
00000004
00000008
0000000c
00000010
00000014
00000018
0000001c
00000020
00000024
0000002c    # beq taken
00000034    # jump
00000038
00000034    # backward branch taken
00000038
0000003c    # final PC, jump to self
11
0 00000000
1 00000006
2 fffffffd
3 00000003
4 00000009
5 00000004
6 0000000f
7 00000001
8 00000000
9 00000000
10 00000002

/* tb/tb_dut_wrapper_soc.sv */
`timescale 1ns/1ns

module tb_dut_wrapper_soc;

    logic                                     sysclk;
    logic                                     reset;
    logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg0;  // Control
    logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg1;  // Debug address
    logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg2;  // ROM control
    logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg3;  // ROM write word
    logic [soc_host_pkg::host_data_width-1:0] read_from_slv_reg4;
    logic [soc_host_pkg::host_data_width-1:0] write_to_slv_reg5;   // PC
    logic [soc_host_pkg::host_data_width-1:0] write_to_slv_reg6;   // ROM read word
    logic [soc_host_pkg::host_data_width-1:0] write_to_slv_reg7;   // Debug register

    // Stimulus and expected values from the data file
    logic [mips_pkg::data_width-1:0]     prog_words [$];
    logic [mips_pkg::data_width-1:0]     step_pcs [$];    // PC after each step
    logic [mips_pkg::data_width-1:0]     final_pc;
    logic [mips_pkg::reg_addr_width-1:0] probe_regs [$];
    logic [mips_pkg::data_width-1:0]     probe_vals [$];

    int fd;
    int seed        = 29;
    int cycle_count = 0;
    int cycle_limit = 0;  // Set once the file is read

    dut_wrapper_soc i_dut_wrapper_soc (
        .sysclk(sysclk), .reset(reset),
        .read_from_slv_reg0(read_from_slv_reg0), .read_from_slv_reg1(read_from_slv_reg1),
        .read_from_slv_reg2(read_from_slv_reg2), .read_from_slv_reg3(read_from_slv_reg3),
        .read_from_slv_reg4(read_from_slv_reg4), .write_to_slv_reg5(write_to_slv_reg5),
        .write_to_slv_reg6(write_to_slv_reg6), .write_to_slv_reg7(write_to_slv_reg7)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;  // 10 ns period
    end

    // Run length guard
    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, test did not finish", cycle_count));
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [31:0] ctrl_word(input logic rst, input logic step,
                                              input logic free_run);
        logic [31:0] w;
        w = '0;
        w[soc_host_pkg::ctrl_rst_bit] = rst;
        w[soc_host_pkg::ctrl_clk_bit] = step;
        w[soc_host_pkg::ctrl_sel_bit] = free_run;
        return w;
    endfunction

    function automatic logic [31:0] rom_ctrl_word(input logic sel, input logic we, input int addr);
        logic [31:0] w;
        w = '0;
        w[soc_host_pkg::rom_sel_bit] = sel;
        w[soc_host_pkg::rom_we_bit]  = we;
        w[soc_host_pkg::rom_addr_lsb +: mips_pkg::rom_addr_width] =
            addr[mips_pkg::rom_addr_width-1:0];
        return w;
    endfunction

    // Next line that is neither blank nor a comment
    task automatic next_line(output string line);
        int rc;
        while (1) begin
            rc = $fgets(line, fd);
            if (rc == 0) abort_run("Stimulus file ended before all sections were read");
            if (line.len() > 1 && line[0] != "#") return;
        end
    endtask

    task automatic read_hex(output logic [mips_pkg::data_width-1:0] value);
        string line;
        next_line(line);
        if ($sscanf(line, "%h", value) != 1) abort_run("Stimulus line is not a hex value");
    endtask

    task automatic read_dec(output int value);
        string line;
        next_line(line);
        if ($sscanf(line, "%d", value) != 1) abort_run("Stimulus line is not a count");
    endtask

    task automatic read_stimulus();
        string                           line;
        int                              count;
        int                              num;
        int                              i;
        logic [mips_pkg::data_width-1:0] value;
        fd = $fopen("tb/soc_stimulus.txt", "r");
        if (fd == 0) abort_run("Cannot open tb/soc_stimulus.txt");
        read_dec(count);
        for (i = 0; i < count; i++) begin
            read_hex(value);
            prog_words.push_back(value);
        end
        read_dec(count);
        for (i = 0; i < count; i++) begin
            read_hex(value);
            step_pcs.push_back(value);
        end
        read_hex(final_pc);
        read_dec(count);
        for (i = 0; i < count; i++) begin
            next_line(line);
            if ($sscanf(line, "%d %h", num, value) != 2) abort_run("Bad register probe line");
            probe_regs.push_back(num[mips_pkg::reg_addr_width-1:0]);
            probe_vals.push_back(value);
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_word(input int addr, input logic [mips_pkg::data_width-1:0] expected,
                              input logic [mips_pkg::data_width-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR write_to_slv_reg6 rom[%0d] expected 0x%08h actual 0x%08h",
                                addr, expected, actual));
        end
    endtask

    task automatic check_pc(input logic [mips_pkg::data_width-1:0] expected,
                            input logic [mips_pkg::data_width-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR write_to_slv_reg5 expected 0x%08h actual 0x%08h",
                                expected, actual));
        end
    endtask

    task automatic check_reg(input logic [mips_pkg::reg_addr_width-1:0] num,
                             input logic [mips_pkg::data_width-1:0] expected,
                             input logic [mips_pkg::data_width-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR write_to_slv_reg7 r%0d expected 0x%08h actual 0x%08h",
                                num, expected, actual));
        end
    endtask

    // One step edge, one instruction, then the PC must hold
    task automatic step_once(input logic [mips_pkg::data_width-1:0] expected);
        logic [mips_pkg::data_width-1:0] prev_pc;
        int                              waited;
        prev_pc = write_to_slv_reg5;
        waited  = 0;
        read_from_slv_reg0 = ctrl_word(1'b0, 1'b1, 1'b0);  // Rising step bit
        @(negedge sysclk);
        read_from_slv_reg0 = ctrl_word(1'b0, 1'b0, 1'b0);
        while (write_to_slv_reg5 == prev_pc && waited < 8) begin
            @(negedge sysclk);
            waited++;
        end
        if (write_to_slv_reg5 == prev_pc) abort_run("PC did not move after a step edge");
        check_pc(expected, write_to_slv_reg5);
        repeat (5) begin
            @(negedge sysclk);
            check_pc(expected, write_to_slv_reg5);  // No edge, no progress
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int                                  i;
        int                                  j;
        int                                  mode;
        logic [mips_pkg::reg_addr_width-1:0] tmp_reg;
        logic [mips_pkg::data_width-1:0]     tmp_val;
        reset              = 1'b1;
        read_from_slv_reg0 = ctrl_word(1'b1, 1'b0, 1'b0);  // Core held in reset
        read_from_slv_reg1 = '0;
        read_from_slv_reg2 = rom_ctrl_word(1'b1, 1'b0, 0);
        read_from_slv_reg3 = '0;
        read_from_slv_reg4 = '0;
        read_stimulus();
        cycle_limit = prog_words.size() * 3 + step_pcs.size() * 10 + 500;
        repeat (10) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;

        // Program load, host owns the port
        for (i = 0; i < prog_words.size(); i++) begin
            read_from_slv_reg2 = rom_ctrl_word(1'b1, 1'b1, i);
            read_from_slv_reg3 = prog_words[i];
            @(negedge sysclk);
        end
        for (i = 0; i < prog_words.size(); i++) begin
            read_from_slv_reg2 = rom_ctrl_word(1'b1, 1'b0, i);
            @(negedge sysclk);
            check_word(i, prog_words[i], write_to_slv_reg6);  // One cycle behind
        end

        // Single step, ROM port handed to the core
        read_from_slv_reg0 = ctrl_word(1'b0, 1'b0, 1'b0);
        read_from_slv_reg2 = '0;
        repeat (6) begin
            @(negedge sysclk);
            check_pc('0, write_to_slv_reg5);  // Longer than one instruction
        end
        for (i = 0; i < step_pcs.size(); i++) begin
            step_once(step_pcs[i]);
        end

        // Free run to the closing self jump
        read_from_slv_reg0 = ctrl_word(1'b0, 1'b0, 1'b1);
        repeat (prog_words.size() * 3 + 20) @(negedge sysclk);
        check_pc(final_pc, write_to_slv_reg5);
        repeat (6) @(negedge sysclk);
        check_pc(final_pc, write_to_slv_reg5);

        // Register probes, shuffled
        for (i = probe_regs.size() - 1; i > 0; i--) begin
            j             = $unsigned($random(seed)) % (i + 1);
            tmp_reg       = probe_regs[i];
            probe_regs[i] = probe_regs[j];
            probe_regs[j] = tmp_reg;
            tmp_val       = probe_vals[i];
            probe_vals[i] = probe_vals[j];
            probe_vals[j] = tmp_val;
        end
        for (i = 0; i < probe_regs.size(); i++) begin
            read_from_slv_reg1 = 32'(probe_regs[i]);
            @(negedge sysclk);
            check_reg(probe_regs[i], probe_vals[i], write_to_slv_reg7);
        end

        // Host reset pulls the PC back to zero in both clock modes
        read_from_slv_reg0 = ctrl_word(1'b1, 1'b0, 1'b1);
        repeat (2) @(negedge sysclk);  // Registered reset reaches the core
        for (mode = 0; mode < 2; mode++) begin
            for (i = 0; i < 6; i++) begin
                read_from_slv_reg0 = ctrl_word(1'b1, i[0], mode[0]);
                @(negedge sysclk);
                check_pc('0, write_to_slv_reg5);
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
